// ==== verilog.f ====
logic/read_cmd_pkg.sv
logic/read_data_pkg.sv
logic/array_struct_demux.sv
logic/cmd_queue.sv
logic/rr_cmd_arbiter.sv
logic/read_path_top.sv
bench/read_path_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the read path testbench with Verilator and runs it.
# The run fails if the log holds the fail message or the simulator exits with an error.

ROOT_DIR=$(cd "$(dirname "$0")" && pwd)
BUILD_DIR=obj_dir
SIM_BIN=read_path_sim
LOG_FILE=sim.log

cd "$ROOT_DIR" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module read_path_tb \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -F -q "*** TEST FAILED ***" "$LOG_FILE"; then
	echo "Simulation reported a failure, see $LOG_FILE"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== bench/read_path_tb.sv ====
`timescale 1ns/1ns

module read_path_tb;

	import read_cmd_pkg::*;
	import read_data_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;
	localparam int QUEUE_DEPTH  = 16;
	localparam int CMD_WAIT     = 64;
	localparam int SETTLE       = 8;
	localparam int DATA_LINES   = 16;
	// Budget per command test covers loading, holding and draining
	localparam int RUN_CYCLES   = RESET_CYCLES + 12 + 4 * (CMD_WAIT + SETTLE + 40) + DATA_LINES + 2;
	localparam int WATCHDOG_NS  = RUN_CYCLES * 3 * CLK_PERIOD;

	logic       clock = 1'b0;
	logic       rstn_internal;
	logic       enabled_in;
	logic       read_command_in_valid;
	cmd_line_t  read_command_in;
	logic       read_data_in_valid;
	data_line_t read_data_in;
	logic       read_buffer_alfull;
	logic       read_command_out_valid;
	cmd_line_t  read_command_out;
	logic       job_data_out_valid;
	data_line_t job_data_out;
	logic       edge_data_out_valid;
	data_line_t edge_data_out;

	logic [15:0] lfsr_state = 16'd87;
	cmd_line_t   exp_job[$];
	cmd_line_t   exp_edge[$];
	cmd_line_t   out_cmds[$];

	read_path_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) dut (
		.clock                 (clock),
		.rstn_internal         (rstn_internal),
		.enabled_in            (enabled_in),
		.read_command_in_valid (read_command_in_valid),
		.read_command_in       (read_command_in),
		.read_data_in_valid    (read_data_in_valid),
		.read_data_in          (read_data_in),
		.read_buffer_alfull    (read_buffer_alfull),
		.read_command_out_valid(read_command_out_valid),
		.read_command_out      (read_command_out),
		.job_data_out_valid    (job_data_out_valid),
		.job_data_out          (job_data_out),
		.edge_data_out_valid   (edge_data_out_valid),
		.edge_data_out         (edge_data_out)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// Collects command outputs at the falling edge where they are stable
	always @(negedge clock) begin
		if (rstn_internal && read_command_out_valid) begin
			out_cmds.push_back(read_command_out);
		end
	end

	////////////////////
	// Helpers
	////////////////////

	// Taps 16, 14, 13, 11
	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r          = {r[62:0], fb};
		end
		return r;
	endfunction

	function automatic array_struct_t random_struct();
		logic [63:0] r;
		r = random_bits(1);
		return r[0] ? struct_edge_data : struct_job;
	endfunction

	function automatic cmd_line_t make_cmd(input array_struct_t kind);
		cmd_line_t   c;
		logic [63:0] r;
		c.array_struct = kind;
		r              = random_bits(32);
		c.address      = r[31:0];
		r              = random_bits(8);
		c.size         = r[7:0];
		r              = random_bits(8);
		c.tag          = r[7:0];
		return c;
	endfunction

	function automatic data_line_t make_data(input array_struct_t kind);
		data_line_t  d;
		logic [63:0] r;
		d.array_struct = kind;
		r              = random_bits(8);
		d.tag          = r[7:0];
		d.data         = random_bits(64);
		return d;
	endfunction

	task automatic stop_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped after the first failure");
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("[ERROR] %0t ns: %s count is %0d, expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_cmd(input cmd_line_t got, input cmd_line_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_data(input data_line_t got, input data_line_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic clear_streams();
		@(posedge clock);
		out_cmds.delete();
		exp_job.delete();
		exp_edge.delete();
	endtask

	// Expected queues are filled as commands go in
	task automatic send_cmd(input cmd_line_t c);
		@(negedge clock);
		read_command_in_valid = 1'b1;
		read_command_in       = c;
		if (c.array_struct == struct_job) begin
			exp_job.push_back(c);
		end else begin
			exp_edge.push_back(c);
		end
	endtask

	task automatic end_burst();
		@(negedge clock);
		read_command_in_valid = 1'b0;
	endtask

	task automatic hold_check(input int cycles, input string what);
		repeat (cycles) begin
			@(negedge clock);
			check_bit(read_command_out_valid, 1'b0, what);
		end
	endtask

	task automatic wait_cmds(input int n, input string what);
		int waited;
		waited = 0;
		while (out_cmds.size() < n) begin
			if (waited >= CMD_WAIT) begin
				$display("Timed out in %s: %0d of %0d commands came out after %0d cycles",
					what, out_cmds.size(), n, waited);
				stop_run();
			end
			@(posedge clock);
			waited++;
		end
		// Room for any extra command to show up
		repeat (SETTLE) @(posedge clock);
	endtask

	// Per-tag order and payload with each command exactly once
	task automatic compare_streams(input string what);
		cmd_line_t got_job[$];
		cmd_line_t got_edge[$];
		foreach (out_cmds[i]) begin
			if (out_cmds[i].array_struct == struct_job) begin
				got_job.push_back(out_cmds[i]);
			end else begin
				got_edge.push_back(out_cmds[i]);
			end
		end
		check_count(got_job.size(), exp_job.size(), {what, " job command"});
		check_count(got_edge.size(), exp_edge.size(), {what, " edge command"});
		foreach (got_job[i]) begin
			check_cmd(got_job[i], exp_job[i], $sformatf("%s job command %0d", what, i));
		end
		foreach (got_edge[i]) begin
			check_cmd(got_edge[i], exp_edge[i], $sformatf("%s edge command %0d", what, i));
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset();
		repeat (12) begin
			@(negedge clock);
			check_bit(read_command_out_valid, 1'b0, "command valid after reset");
			check_bit(job_data_out_valid, 1'b0, "job data valid after reset");
			check_bit(edge_data_out_valid, 1'b0, "edge data valid after reset");
		end
	endtask

	task automatic test_cmd_steering();
		clear_streams();
		@(negedge clock);
		enabled_in         = 1'b1;
		read_buffer_alfull = 1'b0;
		repeat (12) send_cmd(make_cmd(random_struct()));
		end_burst();
		wait_cmds(12, "command steering");
		compare_streams("steering");
	endtask

	task automatic test_round_robin();
		clear_streams();
		@(negedge clock);
		read_buffer_alfull = 1'b1;
		repeat (4) send_cmd(make_cmd(struct_job));
		repeat (4) send_cmd(make_cmd(struct_edge_data));
		end_burst();
		hold_check(8, "command valid while loading queues");
		read_buffer_alfull = 1'b0;
		wait_cmds(8, "round robin");
		compare_streams("round robin");
		for (int i = 1; i < out_cmds.size(); i++) begin
			check_bit(out_cmds[i].array_struct != out_cmds[i - 1].array_struct, 1'b1,
				$sformatf("tag change at round robin output %0d", i));
		end
	endtask

	task automatic test_back_pressure();
		clear_streams();
		@(negedge clock);
		read_buffer_alfull = 1'b1;
		repeat (6) send_cmd(make_cmd(random_struct()));
		end_burst();
		hold_check(20, "command valid under back-pressure");
		read_buffer_alfull = 1'b0;
		wait_cmds(6, "back-pressure release");
		compare_streams("back-pressure");
	endtask

	task automatic test_enable();
		clear_streams();
		@(negedge clock);
		enabled_in = 1'b0;
		hold_check(2, "command valid while disabling");
		repeat (6) send_cmd(make_cmd(random_struct()));
		end_burst();
		hold_check(20, "command valid while disabled");
		enabled_in = 1'b1;
		wait_cmds(6, "enable");
		compare_streams("enable");
	endtask

	// Fixed two-cycle latency with a gap every fourth cycle
	task automatic test_data_steering();
		logic       sent_valid [DATA_LINES];
		data_line_t sent_line  [DATA_LINES];
		logic       vld;
		data_line_t exp;
		for (int c = 0; c < DATA_LINES + 2; c++) begin
			@(negedge clock);
			vld = 1'b0;
			exp = '0;
			if (c >= 2) begin
				vld = sent_valid[c - 2];
				exp = sent_line[c - 2];
			end
			check_bit(job_data_out_valid, vld && exp.array_struct == struct_job, "job data valid");
			check_bit(edge_data_out_valid, vld && exp.array_struct == struct_edge_data,
				"edge data valid");
			if (vld && exp.array_struct == struct_job) begin
				check_data(job_data_out, exp, "job data line");
			end else if (vld) begin
				check_data(edge_data_out, exp, "edge data line");
			end
			if (c < DATA_LINES) begin
				sent_valid[c]      = (c % 4 != 3);
				sent_line[c]       = make_data(random_struct());
				read_data_in_valid = sent_valid[c];
				read_data_in       = sent_line[c];
			end else begin
				read_data_in_valid = 1'b0;
			end
		end
	endtask

	////////////////////
	// Run
	////////////////////

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the run took longer than %0d ns", WATCHDOG_NS);
		stop_run();
	end

	initial begin
		rstn_internal         = 1'b0;
		enabled_in            = 1'b0;
		read_command_in_valid = 1'b0;
		read_command_in       = '0;
		read_data_in_valid    = 1'b0;
		read_data_in          = '0;
		read_buffer_alfull    = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rstn_internal = 1'b1;
		test_reset();
		test_cmd_steering();
		test_round_robin();
		test_back_pressure();
		test_enable();
		test_data_steering();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== logic/read_path_top.sv ====
`timescale 1ns/1ns

module read_path_top #(
	parameter int QUEUE_DEPTH = 16
) (
	input  logic                      clock,
	input  logic                      rstn_internal,
	input  logic                      enabled_in,
	input  logic                      read_command_in_valid,
	input  read_cmd_pkg::cmd_line_t   read_command_in,
	input  logic                      read_data_in_valid,
	input  read_data_pkg::data_line_t read_data_in,
	input  logic                      read_buffer_alfull,
	output logic                      read_command_out_valid,
	output read_cmd_pkg::cmd_line_t   read_command_out,
	output logic                      job_data_out_valid,
	output read_data_pkg::data_line_t job_data_out,
	output logic                      edge_data_out_valid,
	output read_data_pkg::data_line_t edge_data_out
);

	import read_cmd_pkg::*;
	import read_data_pkg::*;

	logic       enabled;
	logic       read_buffer_alfull_latched;
	logic       read_command_in_valid_latched;
	cmd_line_t  read_command_in_latched;
	logic       read_data_in_valid_latched;
	data_line_t read_data_in_latched;

	logic [NUM_ARRAY_STRUCTS-1:0] cmd_valid;
	cmd_line_t                    cmd_payload;
	logic [NUM_ARRAY_STRUCTS-1:0] data_valid;
	data_line_t                   data_payload;

	cmd_line_t                    queue_head [NUM_ARRAY_STRUCTS];
	logic [NUM_ARRAY_STRUCTS-1:0] queue_empty;
	logic [NUM_ARRAY_STRUCTS-1:0] queue_pop;

	////////////////////
	// Input latches
	////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			enabled                       <= 1'b0;
			// Hold off grants until the buffer level has been sampled
			read_buffer_alfull_latched    <= 1'b1;
			read_command_in_valid_latched <= 1'b0;
			read_data_in_valid_latched    <= 1'b0;
		end else begin
			enabled                       <= enabled_in;
			read_buffer_alfull_latched    <= read_buffer_alfull;
			read_command_in_valid_latched <= read_command_in_valid;
			read_data_in_valid_latched    <= read_data_in_valid;
		end
	end

	always_ff @(posedge clock) begin
		read_command_in_latched <= read_command_in;
		read_data_in_latched    <= read_data_in;
	end

	////////////////////
	// Command path
	////////////////////

	array_struct_demux #(
		.payload_t(cmd_line_t)
	) cmd_demux (
		.clock        (clock),
		.rstn_internal(rstn_internal),
		.in_valid     (read_command_in_valid_latched),
		.in_payload   (read_command_in_latched),
		.out_valid    (cmd_valid),
		.out_payload  (cmd_payload)
	);

	// Job commands
	cmd_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) job_queue (
		.clock        (clock),
		.rstn_internal(rstn_internal),
		.push         (cmd_valid[struct_job]),
		.push_cmd     (cmd_payload),
		.pop          (queue_pop[struct_job]),
		.head_cmd     (queue_head[struct_job]),
		.empty        (queue_empty[struct_job]),
		.full         (),
		.alfull       ()
	);

	// Edge-data commands
	cmd_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) edge_data_queue (
		.clock        (clock),
		.rstn_internal(rstn_internal),
		.push         (cmd_valid[struct_edge_data]),
		.push_cmd     (cmd_payload),
		.pop          (queue_pop[struct_edge_data]),
		.head_cmd     (queue_head[struct_edge_data]),
		.empty        (queue_empty[struct_edge_data]),
		.full         (),
		.alfull       ()
	);

	// Grant register is the command output register
	rr_cmd_arbiter #(
		.NUM_REQUESTS(NUM_ARRAY_STRUCTS)
	) cmd_arbiter (
		.clock             (clock),
		.rstn_internal     (rstn_internal),
		.enabled           (enabled),
		.read_buffer_alfull(read_buffer_alfull_latched),
		.empty             (queue_empty),
		.head_cmd          (queue_head),
		.pop               (queue_pop),
		.grant_valid       (read_command_out_valid),
		.grant_cmd         (read_command_out)
	);

	////////////////////
	// Data path
	////////////////////

	// Independent of enable
	array_struct_demux #(
		.payload_t(data_line_t)
	) data_demux (
		.clock        (clock),
		.rstn_internal(rstn_internal),
		.in_valid     (read_data_in_valid_latched),
		.in_payload   (read_data_in_latched),
		.out_valid    (data_valid),
		.out_payload  (data_payload)
	);

	assign job_data_out_valid  = data_valid[struct_job];
	assign job_data_out        = data_payload;
	assign edge_data_out_valid = data_valid[struct_edge_data];
	assign edge_data_out       = data_payload;

endmodule

// ==== logic/rr_cmd_arbiter.sv ====
`timescale 1ns/1ns

module rr_cmd_arbiter #(
	parameter int NUM_REQUESTS = 2
) (
	input  logic                    clock,
	input  logic                    rstn_internal,
	input  logic                    enabled,
	input  logic                    read_buffer_alfull,
	input  logic [NUM_REQUESTS-1:0] empty,
	input  read_cmd_pkg::cmd_line_t head_cmd [NUM_REQUESTS],
	output logic [NUM_REQUESTS-1:0] pop,
	output logic                    grant_valid,
	output read_cmd_pkg::cmd_line_t grant_cmd
);

	import read_cmd_pkg::*;

	localparam int PTR_W = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [PTR_W-1:0] rr_ptr;
	logic [PTR_W-1:0] winner;
	logic             found;
	logic             grant_go;

	////////////////////
	// Winner search
	////////////////////

	// First non-empty queue at or after the pointer with wraparound
	always_comb begin
		int idx;
		found  = 1'b0;
		winner = '0;
		for (int k = 0; k < NUM_REQUESTS; k++) begin
			idx = (int'(rr_ptr) + k) % NUM_REQUESTS;
			if (!found && !empty[idx]) begin
				found  = 1'b1;
				winner = PTR_W'(idx);
			end
		end
	end

	// No grant while disabled or the read buffer is nearly full
	assign grant_go = found && enabled && !read_buffer_alfull;

	always_comb begin
		pop = '0;
		if (grant_go) begin
			pop[winner] = 1'b1;
		end
	end

	////////////////////
	// Grant register
	////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			grant_valid <= 1'b0;
			// Job queue goes first after reset
			rr_ptr      <= PTR_W'(struct_job);
		end else begin
			grant_valid <= grant_go;
			if (grant_go) begin
				rr_ptr <= (winner == PTR_W'(NUM_REQUESTS - 1)) ? '0 : winner + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (grant_go) begin
			grant_cmd <= head_cmd[winner];
		end
	end

	////////////////////
	// Checks
	////////////////////

	assert property (@(posedge clock) disable iff (!rstn_internal)
		$onehot0(pop));

endmodule

// ==== logic/cmd_queue.sv ====
`timescale 1ns/1ns

module cmd_queue #(
	parameter int QUEUE_DEPTH = 16
) (
	input  logic                    clock,
	input  logic                    rstn_internal,
	input  logic                    push,
	input  read_cmd_pkg::cmd_line_t push_cmd,
	input  logic                    pop,
	output read_cmd_pkg::cmd_line_t head_cmd,
	output logic                    empty,
	output logic                    full,
	output logic                    alfull
);

	import read_cmd_pkg::*;

	localparam int PTR_W   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);

	cmd_line_t          mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [COUNT_W-1:0] count;
	logic               do_push;
	logic               do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	// Head is visible without a pop
	assign head_cmd = mem[rd_ptr];

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Levels
	assign empty  = (count == '0);
	assign full   = (count == COUNT_W'(QUEUE_DEPTH));
	// Two or fewer free slots
	assign alfull = (int'(count) >= QUEUE_DEPTH - 2);

	////////////////////
	// Checks
	////////////////////

	// Writer must watch full
	assert property (@(posedge clock) disable iff (!rstn_internal)
		push |-> !full);

	// Arbiter must only pop a queue it saw as non-empty
	assert property (@(posedge clock) disable iff (!rstn_internal)
		pop |-> !empty);

endmodule

// ==== logic/array_struct_demux.sv ====
`timescale 1ns/1ns

module array_struct_demux #(
	parameter type payload_t = read_cmd_pkg::cmd_line_t
) (
	input  logic                                         clock,
	input  logic                                         rstn_internal,
	input  logic                                         in_valid,
	input  payload_t                                     in_payload,
	output logic [read_cmd_pkg::NUM_ARRAY_STRUCTS-1:0]   out_valid,
	output payload_t                                     out_payload
);

	import read_cmd_pkg::*;

	////////////////////
	// Steering register
	////////////////////

	// One strobe per tag selected by the payload's own tag field
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			out_valid <= '0;
		end else begin
			for (int i = 0; i < NUM_ARRAY_STRUCTS; i++) begin
				out_valid[i] <= in_valid && (in_payload.array_struct == array_struct_t'(i));
			end
		end
	end

	// Payload is shared by all outputs
	always_ff @(posedge clock) begin
		out_payload <= in_payload;
	end

	////////////////////
	// Checks
	////////////////////

	// At most one destination per item
	assert property (@(posedge clock) disable iff (!rstn_internal)
		$onehot0(out_valid));

endmodule

// ==== logic/read_data_pkg.sv ====
package read_data_pkg;

	////////////////////
	// Read data line
	////////////////////

	localparam int DATA_TAG_WIDTH = 8;
	localparam int DATA_WIDTH     = 64;

	// Tag is echoed back from the command that fetched the line
	typedef struct packed {
		read_cmd_pkg::array_struct_t array_struct;
		logic [DATA_TAG_WIDTH-1:0]   tag;
		logic [DATA_WIDTH-1:0]       data;
	} data_line_t;

endpackage

// ==== logic/read_cmd_pkg.sv ====
package read_cmd_pkg;

	////////////////////
	// Array structures
	////////////////////

	// Which graph array a read belongs to
	typedef enum logic {
		struct_job       = 1'b0,
		struct_edge_data = 1'b1
	} array_struct_t;

	localparam int NUM_ARRAY_STRUCTS = 2;

	////////////////////
	// Read command line
	////////////////////

	localparam int CMD_ADDRESS_WIDTH = 32;
	localparam int CMD_SIZE_WIDTH    = 8;
	localparam int CMD_TAG_WIDTH     = 8;

	// Steering tag sits on top so it is the MSB of the line
	typedef struct packed {
		array_struct_t                array_struct;
		logic [CMD_ADDRESS_WIDTH-1:0] address;
		logic [CMD_SIZE_WIDTH-1:0]    size;
		logic [CMD_TAG_WIDTH-1:0]     tag;
	} cmd_line_t;

endpackage
